// ==== hw/dac_mixer.sv ====
// ==============================
// sums enabled direct outputs into the two dac channels
// pipelined pair/tree adder, clamp to 14 bits, latency MIX_LAT
// ==============================
`timescale 1ns/1ps
`default_nettype none

module dac_mixer #(
   parameter int N_SLOTS = 8
) (
   input  logic                             clk_i,
   input  logic                             rstn_i,
   input  dsp_pkg::sig_t [N_SLOTS-1:0]      slot_dat_i,  // slot direct outputs
   input  dsp_pkg::sig_t                    asg1_i,
   input  dsp_pkg::sig_t                    asg2_i,
   input  dsp_pkg::dac_en_t [N_SLOTS+1:0]   out_sel_i,   // per direct output
   output dsp_pkg::sig_t                    dac_a_o,
   output dsp_pkg::sig_t                    dac_b_o,
   output logic [1:0]                       sat_o        // {dac2, dac1}
);
   import dsp_pkg::*;

   localparam int SUM_W  = SIG_W + 4;   // 16 leaves need 4 guard bits
   localparam int N_LEAF = 16;
   localparam int N_DIR  = N_SLOTS + 2;
   localparam logic signed [SUM_W-1:0] SAT_MAX = SUM_W'(2**(SIG_W-1) - 1);
   localparam logic signed [SUM_W-1:0] SAT_MIN = SUM_W'(-(2**(SIG_W-1)));

   sig_t    dir_dat [N_LEAF];  // padded direct outputs
   dac_en_t dir_en  [N_LEAF];
   sig_t    dac_q   [2];
   logic    [1:0] sat_q;

   // pad to 16 leaves, spare leaves never enabled
   for (genvar k = 0; k < N_LEAF; k++) begin : g_dir
      if (k < N_SLOTS) begin : g_slot
         assign dir_dat[k] = slot_dat_i[k];
         assign dir_en[k]  = out_sel_i[k];
      end else if (k < N_DIR) begin : g_asg
         assign dir_dat[k] = (k == N_SLOTS) ? asg1_i : asg2_i;
         assign dir_en[k]  = out_sel_i[k];
      end else begin : g_pad
         assign dir_dat[k] = '0;
         assign dir_en[k]  = DAC_OFF;
      end
   end

   // one identical tree per channel, ch 0 is dac1
   for (genvar ch = 0; ch < 2; ch++) begin : g_ch
      logic signed [SUM_W-1:0] leaf   [N_LEAF];
      logic signed [SUM_W-1:0] pair_q [8];
      logic signed [SUM_W-1:0] lvl1_q [4];
      logic signed [SUM_W-1:0] lvl2_q [2];
      logic signed [SUM_W-1:0] lvl3_q;
      sig_t                    dac_d;
      logic                    sat_d;

      // sign extend and mask by enable bit
      for (genvar k = 0; k < N_LEAF; k++) begin : g_leaf
         assign leaf[k] = dir_en[k][ch] ?
                          {{(SUM_W-SIG_W){dir_dat[k][SIG_W-1]}}, dir_dat[k]} : '0;
      end

      always_ff @(posedge clk_i) begin
         if (!rstn_i) begin
            for (int i = 0; i < 8; i++) pair_q[i] <= '0;
            for (int i = 0; i < 4; i++) lvl1_q[i] <= '0;
            lvl2_q[0] <= '0;
            lvl2_q[1] <= '0;
            lvl3_q    <= '0;
         end else begin
            for (int i = 0; i < 8; i++)
               pair_q[i] <= leaf[2*i] + leaf[2*i+1];       // stage 1
            for (int i = 0; i < 4; i++)
               lvl1_q[i] <= pair_q[2*i] + pair_q[2*i+1];   // stage 2
            lvl2_q[0] <= lvl1_q[0] + lvl1_q[1];            // stage 3
            lvl2_q[1] <= lvl1_q[2] + lvl1_q[3];
            lvl3_q    <= lvl2_q[0] + lvl2_q[1];            // stage 4
         end
      end

      // clamp to the dac range
      always_comb begin
         sat_d = 1'b1;
         if (lvl3_q > SAT_MAX)
            dac_d = SAT_MAX[SIG_W-1:0];
         else if (lvl3_q < SAT_MIN)
            dac_d = SAT_MIN[SIG_W-1:0];
         else begin
            dac_d = lvl3_q[SIG_W-1:0];
            sat_d = 1'b0;
         end
      end

      always_ff @(posedge clk_i) begin   // stage 5, output reg
         if (!rstn_i) begin
            dac_q[ch] <= '0;
            sat_q[ch] <= 1'b0;
         end else begin
            dac_q[ch] <= dac_d;
            sat_q[ch] <= sat_d;  // aligned with its sample
         end
      end
   end

   assign dac_a_o = dac_q[0];
   assign dac_b_o = dac_q[1];
   assign sat_o   = sat_q;

endmodule

`default_nettype wire

// ==== hw/dsp_pkg.sv ====
// ==============================
// shared widths, source codes and register map of the dsp router
// imported by the reg bank, crossbar and mixer
// ==============================
`default_nettype none

package dsp_pkg;

   // sample and select widths
   localparam int SIG_W = 14;  // adc/dac sample width
   localparam int SEL_W = 4;   // source code and address index width

   typedef logic signed [SIG_W-1:0] sig_t;  // one sample
   typedef logic [SEL_W-1:0]        sel_t;  // source code
   typedef logic [1:0]              dac_en_t;  // bit 0 dac1, bit 1 dac2

   // source codes after the slots, add N_SLOTS
   localparam int SRC_ASG1 = 0;
   localparam int SRC_ASG2 = 1;
   localparam int SRC_ADC1 = 2;
   localparam int SRC_ADC2 = 3;
   localparam int SRC_DAC1 = 4;  // mixer output fed back
   localparam int SRC_DAC2 = 5;

   // selects zero on any sink
   localparam sel_t SEL_NONE = 4'd15;

   // dac enable codes for the output select registers
   localparam dac_en_t DAC_OFF  = 2'b00;
   localparam dac_en_t DAC_OUT1 = 2'b01;
   localparam dac_en_t DAC_OUT2 = 2'b10;
   localparam dac_en_t DAC_BOTH = 2'b11;

   // register offsets, address bits 15:0
   localparam logic [15:0] OFS_INPUT_SEL  = 16'h0000;
   localparam logic [15:0] OFS_OUTPUT_SEL = 16'h0004;
   localparam logic [15:0] OFS_SAT        = 16'h0008;
   localparam logic [15:0] OFS_SYNC       = 16'h000C;
   localparam logic [15:0] OFS_SIGNAL     = 16'h0010;

   // pair stage + three tree levels + output reg
   localparam int MIX_LAT = 5;

endpackage

`default_nettype wire

// ==== hw/dsp_reg_bank.sv ====
// ==============================
// routing registers on the sys bus
// index in addr 19:16, offset in 15:0, ack one cycle after request
// ==============================
`timescale 1ns/1ps
`default_nettype none

module dsp_reg_bank #(
   parameter int N_SLOTS = 8
) (
   input  logic                                 clk_i,
   input  logic                                 rstn_i,
   // sys bus
   input  logic [31:0]                          sys_addr_i,
   input  logic [31:0]                          sys_wdata_i,
   input  logic                                 sys_wen_i,
   input  logic                                 sys_ren_i,
   output logic [31:0]                          sys_rdata_o,
   output logic                                 sys_ack_o,
   output logic                                 sys_err_o,
   // status and readback from the datapath
   input  logic [1:0]                           sat_i,        // {dac2, dac1}
   input  dsp_pkg::sig_t                        src_value_i,  // value at src_idx_o
   // routing state
   output dsp_pkg::sel_t   [N_SLOTS+1:0]        in_sel_o,
   output dsp_pkg::dac_en_t [N_SLOTS+1:0]       out_sel_o,
   output logic [N_SLOTS-1:0]                   sync_o,
   output dsp_pkg::sel_t                        src_idx_o
);
   import dsp_pkg::*;

   localparam int N_SINK = N_SLOTS + 2;  // slots + two scopes / two asg

   sel_t                 in_sel_q  [N_SINK];
   dac_en_t              out_sel_q [N_SINK];
   logic [N_SLOTS-1:0]   sync_q;

   sel_t                 idx;
   logic [15:0]          ofs;
   logic                 idx_ok;   // index names an existing sink
   logic                 req;      // read or write this cycle

   logic [31:0]          rdata_d;
   logic                 err_d;

   assign idx    = sys_addr_i[16 +: SEL_W];
   assign ofs    = sys_addr_i[15:0];
   assign idx_ok = (idx < SEL_W'(N_SINK));
   assign req    = sys_wen_i | sys_ren_i;

   // register writes, reset gives the default routing
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int k = 0; k < N_SINK; k++) begin
            in_sel_q[k]  <= sel_t'(N_SLOTS + SRC_ADC1);  // every sink on adc1
            out_sel_q[k] <= DAC_OFF;
         end
         in_sel_q[N_SLOTS+1] <= sel_t'(N_SLOTS + SRC_ADC2);  // scope2 on adc2
         sync_q <= '1;  // all slots running
      end else if (sys_wen_i && idx_ok) begin
         case (ofs)
            OFS_INPUT_SEL:  in_sel_q[idx]  <= sys_wdata_i[SEL_W-1:0];
            OFS_OUTPUT_SEL: out_sel_q[idx] <= sys_wdata_i[1:0];
            OFS_SYNC:       sync_q         <= sys_wdata_i[N_SLOTS-1:0];
            default: ;  // status and signal are read only
         endcase
      end
   end

   // read mux
   always_comb begin
      rdata_d = '0;
      err_d   = 1'b0;
      case (ofs)
         OFS_INPUT_SEL: begin
            if (idx_ok)
               rdata_d = {{(32-SEL_W){1'b0}}, in_sel_q[idx]};
         end
         OFS_OUTPUT_SEL: begin
            if (idx_ok)
               rdata_d = {30'b0, out_sel_q[idx]};
         end
         OFS_SAT:    rdata_d = {30'b0, sat_i};  // live clamp flags
         OFS_SYNC:   rdata_d = {{(32-N_SLOTS){1'b0}}, sync_q};
         // crossbar already gives zero for unused codes
         OFS_SIGNAL: rdata_d = {{(32-SIG_W){1'b0}}, src_value_i};
         default:    err_d = 1'b1;  // unmapped offset
      endcase
   end

   // handshake, one request per cycle
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         sys_ack_o <= 1'b0;
         sys_err_o <= 1'b0;
      end else begin
         sys_ack_o <= req;
         sys_err_o <= req & err_d;
      end
   end

   // read data only moves with a request
   always_ff @(posedge clk_i) begin
      if (req)
         sys_rdata_o <= rdata_d;
   end

   // flatten the register arrays onto the ports
   always_comb begin
      for (int k = 0; k < N_SINK; k++) begin
         in_sel_o[k]  = in_sel_q[k];
         out_sel_o[k] = out_sel_q[k];
      end
   end

   assign sync_o    = sync_q;
   assign src_idx_o = idx;  // lookup for OFS_SIGNAL

endmodule

`default_nettype wire

// ==== hw/dsp_router_top.sv ====
// ==============================
// signal router and dac mixer of the servo dsp core
// slots live outside, their data crosses slot_dat_i / slot_dat_o
// ==============================
`timescale 1ns/1ps
`default_nettype none

module dsp_router_top #(
   parameter int N_SLOTS = 8   // 1 to 9
) (
   input  logic                          clk_i,
   input  logic                          rstn_i,
   // converters and generators
   input  dsp_pkg::sig_t                 adc_a_i,
   input  dsp_pkg::sig_t                 adc_b_i,
   input  dsp_pkg::sig_t                 asg1_i,
   input  dsp_pkg::sig_t                 asg2_i,
   output dsp_pkg::sig_t                 dac_a_o,
   output dsp_pkg::sig_t                 dac_b_o,
   output dsp_pkg::sig_t                 scope1_o,
   output dsp_pkg::sig_t                 scope2_o,
   // external processing slots
   input  dsp_pkg::sig_t [N_SLOTS-1:0]   slot_dat_i,  // slot results
   output dsp_pkg::sig_t [N_SLOTS-1:0]   slot_dat_o,  // slot inputs
   output logic [N_SLOTS-1:0]            sync_o,
   // sys bus
   input  logic [31:0]                   sys_addr_i,
   input  logic [31:0]                   sys_wdata_i,
   input  logic                          sys_wen_i,
   input  logic                          sys_ren_i,
   output logic [31:0]                   sys_rdata_o,
   output logic                          sys_ack_o,
   output logic                          sys_err_o
);
   import dsp_pkg::*;

   sel_t    [N_SLOTS+1:0] in_sel;
   dac_en_t [N_SLOTS+1:0] out_sel;
   sel_t                  src_idx;    // bus index used as source code
   sig_t                  src_value;
   logic    [1:0]         sat;

   dsp_reg_bank #(.N_SLOTS(N_SLOTS)) u_reg_bank (
      .clk_i       (clk_i),
      .rstn_i      (rstn_i),
      .sys_addr_i  (sys_addr_i),
      .sys_wdata_i (sys_wdata_i),
      .sys_wen_i   (sys_wen_i),
      .sys_ren_i   (sys_ren_i),
      .sys_rdata_o (sys_rdata_o),
      .sys_ack_o   (sys_ack_o),
      .sys_err_o   (sys_err_o),
      .sat_i       (sat),
      .src_value_i (src_value),
      .in_sel_o    (in_sel),
      .out_sel_o   (out_sel),
      .sync_o      (sync_o),
      .src_idx_o   (src_idx)
   );

   signal_crossbar #(.N_SLOTS(N_SLOTS)) u_crossbar (
      .slot_dat_i  (slot_dat_i),
      .asg1_i      (asg1_i),
      .asg2_i      (asg2_i),
      .adc_a_i     (adc_a_i),
      .adc_b_i     (adc_b_i),
      .dac_a_i     (dac_a_o),    // feedback from mixer regs
      .dac_b_i     (dac_b_o),
      .in_sel_i    (in_sel),
      .src_idx_i   (src_idx),
      .slot_dat_o  (slot_dat_o),
      .scope1_o    (scope1_o),
      .scope2_o    (scope2_o),
      .src_value_o (src_value)
   );

   // direct outputs are the slot results and the generators
   dac_mixer #(.N_SLOTS(N_SLOTS)) u_mixer (
      .clk_i       (clk_i),
      .rstn_i      (rstn_i),
      .slot_dat_i  (slot_dat_i),
      .asg1_i      (asg1_i),
      .asg2_i      (asg2_i),
      .out_sel_i   (out_sel),
      .dac_a_o     (dac_a_o),
      .dac_b_o     (dac_b_o),
      .sat_o       (sat)
   );

endmodule

`default_nettype wire

// ==== hw/signal_crossbar.sv ====
// ==============================
// source table in code order and per-sink input select
// combinational and also serves bus readback of one source
// ==============================
`timescale 1ns/1ps
`default_nettype none

module signal_crossbar #(
   parameter int N_SLOTS = 8
) (
   input  dsp_pkg::sig_t [N_SLOTS-1:0]   slot_dat_i,  // slot outputs
   input  dsp_pkg::sig_t                 asg1_i,
   input  dsp_pkg::sig_t                 asg2_i,
   input  dsp_pkg::sig_t                 adc_a_i,
   input  dsp_pkg::sig_t                 adc_b_i,
   input  dsp_pkg::sig_t                 dac_a_i,     // registered mixer output
   input  dsp_pkg::sig_t                 dac_b_i,
   input  dsp_pkg::sel_t [N_SLOTS+1:0]   in_sel_i,
   input  dsp_pkg::sel_t                 src_idx_i,
   output dsp_pkg::sig_t [N_SLOTS-1:0]   slot_dat_o,  // slot inputs
   output dsp_pkg::sig_t                 scope1_o,
   output dsp_pkg::sig_t                 scope2_o,
   output dsp_pkg::sig_t                 src_value_o
);
   import dsp_pkg::*;

   localparam int N_CODE = 2**SEL_W;    // full code space so unused codes read 0
   localparam int N_SINK = N_SLOTS + 2;

   sig_t src_tab  [N_CODE];
   sig_t sink_dat [N_SINK];

   // one table entry per source code
   for (genvar k = 0; k < N_CODE; k++) begin : g_src
      if (k < N_SLOTS) begin : g_slot
         assign src_tab[k] = slot_dat_i[k];
      end else if (k == N_SLOTS + SRC_ASG1) begin : g_asg1
         assign src_tab[k] = asg1_i;
      end else if (k == N_SLOTS + SRC_ASG2) begin : g_asg2
         assign src_tab[k] = asg2_i;
      end else if (k == N_SLOTS + SRC_ADC1) begin : g_adc1
         assign src_tab[k] = adc_a_i;
      end else if (k == N_SLOTS + SRC_ADC2) begin : g_adc2
         assign src_tab[k] = adc_b_i;
      end else if (k == N_SLOTS + SRC_DAC1) begin : g_dac1
         assign src_tab[k] = dac_a_i;
      end else if (k == N_SLOTS + SRC_DAC2) begin : g_dac2
         assign src_tab[k] = dac_b_i;
      end else begin : g_unused
         assign src_tab[k] = '0;  // includes SEL_NONE
      end
   end

   // each sink reads its selected table entry
   for (genvar j = 0; j < N_SINK; j++) begin : g_sink
      assign sink_dat[j] = src_tab[in_sel_i[j]];  // NONE lands on a zero entry
   end

   for (genvar j = 0; j < N_SLOTS; j++) begin : g_slot_out
      assign slot_dat_o[j] = sink_dat[j];
   end

   assign scope1_o    = sink_dat[N_SLOTS];
   assign scope2_o    = sink_dat[N_SLOTS+1];
   assign src_value_o = src_tab[src_idx_i];  // bus readback

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the dsp router testbench with Verilator and runs it.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing -Wno-fatal -f verilog.f \
   --top-module tb_dsp_router -o tb_dsp_router > "$build_log" 2>&1
if [ $? -ne 0 ]; then
   echo "verilator build failed, see $build_log"
   exit 1
fi

./obj_dir/tb_dsp_router > "$sim_log" 2>&1
if [ $? -ne 0 ]; then
   echo "simulation exited with an error, see $sim_log"
   exit 1
fi

if grep -q "^STATUS: PASS$" "$sim_log"; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed, see $sim_log"
   exit 1
fi

// ==== test/router_trace.txt ====
# columns: test op a b c d, all values hex
# wr idx ofs data | rd idx ofs exp err | set src val | chk sink(a=sync) exp | rnd mag | dac exp1 exp2 | mix
rst_sel_slot rd 7 0 a 0
rst_sel_scope1 rd 8 0 a 0
rst_sel_scope2 rd 9 0 b 0
rst_enable_slot rd 0 4 0 0
rst_enable_asg rd 9 4 0 0
rst_sync rd 0 c ff 0
rst_dac dac 0 0 0 0
sync_wr wr 0 c a5 0
sync_rd rd 0 c a5 0
sync_pins chk a a5 0 0
oor_wr wr a 0 5 0
oor_rd rd a 0 0 0
oor_keep rd 0 0 a 0
bad_offset rd 0 14 0 1
route_slot_val set 3 123 0 0
route_scope1_sel wr 8 0 3 0
route_scope1_chk chk 8 123 0 0
route_scope2_none wr 9 0 f 0
route_scope2_chk chk 9 0 0 0
route_adc2_val set b 1abc 0 0
route_slot5_sel wr 5 0 b 0
route_slot5_rd rd 5 0 b 0
route_slot5_chk chk 5 1abc 0 0
signal_rd rd b 10 1abc 0
en_slot0 wr 0 4 1 0
en_slot1 wr 1 4 2 0
en_slot2 wr 2 4 3 0
en_slot3 wr 3 4 1 0
en_asg1 wr 8 4 3 0
en_asg2 wr 9 4 2 0
en_asg1_rd rd 8 4 3 0
mix_small rnd 2ff 0 0 0
mix_small_chk mix 0 0 0 0
mix_large rnd 1fff 0 0 0
mix_large_chk mix 0 0 0 0
sat_slot0 set 0 1800 0 0
sat_slot1 set 1 2000 0 0
sat_slot2 set 2 0 0 0
sat_slot3 set 3 1000 0 0
sat_asg1 set 8 0 0 0
sat_asg2 set 9 3000 0 0
sat_dac dac 1fff 2000 0 0
sat_flags rd 0 8 3 0
fb_scope1_sel wr 8 0 c 0
fb_scope1_chk chk 8 1fff 0 0
clr_slot0 set 0 100 0 0
clr_slot1 set 1 3f00 0 0
clr_dac dac 1100 2f00 0 0
clr_flags rd 0 8 0 0
clr_scope1_chk chk 8 1100 0 0

// ==== test/tb_dsp_router.sv ====
// ==============================
// trace driven testbench of the dsp router
// each line of test/router_trace.txt is one bus, stimulus or check step
// ==============================
`timescale 1ns/1ps
`default_nettype none

module tb_dsp_router;
   import dsp_pkg::*;

   localparam int N_SLOTS = 8;
   localparam int N_DIR   = N_SLOTS + 2;  // direct outputs as slots then asg1/asg2

   logic clk_i = 1'b0;
   logic rstn_i;
   sig_t adc_a, adc_b, asg1, asg2, dac_a, dac_b, scope1, scope2;
   sig_t [N_SLOTS-1:0] slot_in;
   sig_t [N_SLOTS-1:0] slot_out;
   logic [N_SLOTS-1:0] sync;
   logic [31:0] sys_addr, sys_wdata, sys_rdata;
   logic sys_wen, sys_ren, sys_ack, sys_err;

   // parsed trace with one entry per operation
   logic [8*24-1:0] q_name[$];
   logic [8*8-1:0]  q_op[$];
   logic [31:0]     q_a[$], q_b[$], q_c[$], q_d[$];
   bit              trace_loaded = 1'b0;

   int          mism_cnt  = 0;
   int          other_cnt = 0;  // ack, file and format problems
   logic [31:0] rng_state = 32'hd180_e682;
   int          dir_val [N_DIR];  // reference copy of slot/asg stimulus
   logic [1:0]  en_model [N_DIR];  // reference copy of output selects

   always #20 clk_i = ~clk_i;  // 40 ns

   dsp_router_top #(.N_SLOTS(N_SLOTS)) u_dut (
      .clk_i (clk_i), .rstn_i (rstn_i),
      .adc_a_i (adc_a), .adc_b_i (adc_b), .asg1_i (asg1), .asg2_i (asg2),
      .dac_a_o (dac_a), .dac_b_o (dac_b), .scope1_o (scope1), .scope2_o (scope2),
      .slot_dat_i (slot_in), .slot_dat_o (slot_out), .sync_o (sync),
      .sys_addr_i (sys_addr), .sys_wdata_i (sys_wdata),
      .sys_wen_i (sys_wen), .sys_ren_i (sys_ren),
      .sys_rdata_o (sys_rdata), .sys_ack_o (sys_ack), .sys_err_o (sys_err)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // dac rule clamps to 14 bit signed and shows the raw 14 bits
   function automatic logic [31:0] expect_dac(input int sum);
      int s;
      s = sum;
      if (s > 8191) s = 8191;
      else if (s < -8192) s = -8192;
      return 32'(s) & 32'h3fff;
   endfunction

   // 0..7 slot inputs, 8/9 scopes, 10 sync pins
   function automatic logic [31:0] sink_value(input logic [31:0] sink);
      if (sink < N_SLOTS) return {18'b0, slot_out[sink[2:0]]};
      else if (sink == 8) return {18'b0, scope1};
      else if (sink == 9) return {18'b0, scope2};
      else if (sink == 10) return {24'b0, sync};
      return '0;
   endfunction

   task automatic check_value(input logic [8*24-1:0] name, input logic [31:0] exp, act);
      if (exp !== act) begin
         mism_cnt++;
         $display("MISMATCH %0s: expected %h, actual %h", name, exp, act);
      end
   endtask

   // drives in source code order right after a rising edge
   task automatic drive_source(input int code, input logic [13:0] val);
      if (code < N_SLOTS) slot_in[code[2:0]] <= val;
      else if (code == N_SLOTS) asg1 <= val;
      else if (code == N_SLOTS + 1) asg2 <= val;
      else if (code == N_SLOTS + 2) adc_a <= val;
      else if (code == N_SLOTS + 3) adc_b <= val;
      if (code < N_DIR) dir_val[code] = $signed(val);  // sign extend
   endtask

   task automatic bus_access(input logic [8*24-1:0] name, input logic wr,
                             input logic [31:0] idx, ofs, data,
                             output logic [31:0] rdata, output logic err, output logic ok);
      int wait_cyc;
      @(posedge clk_i);
      sys_addr  <= {12'b0, idx[3:0], ofs[15:0]};
      sys_wdata <= data;
      sys_wen   <= wr;
      sys_ren   <= !wr;
      @(posedge clk_i);  // request taken here
      sys_wen   <= 1'b0;
      sys_ren   <= 1'b0;
      ok = 1'b0;
      rdata = '0;
      err = 1'b0;
      wait_cyc = 0;
      while (!ok && wait_cyc < 2) begin
         @(negedge clk_i);
         if (sys_ack) begin
            ok = 1'b1;
            rdata = sys_rdata;
            err = sys_err;
         end
         wait_cyc++;
      end
      if (!ok) begin
         other_cnt++;
         $display("%0s: sys bus gave no ack within two cycles", name);
      end
   endtask

   task automatic wait_mix();
      repeat (MIX_LAT + 1) @(posedge clk_i);
      @(negedge clk_i);  // outputs settled mid cycle
   endtask

   task automatic run_op(input logic [8*24-1:0] name, input logic [8*8-1:0] op,
                         input logic [31:0] a, b, c, d);
      logic [31:0] rdata;
      logic        err, ok;
      int          v, s1, s2;
      case (op)
         "wr": begin
            bus_access(name, 1'b1, a, b, c, rdata, err, ok);
            if (b == 32'(OFS_OUTPUT_SEL) && a < N_DIR) en_model[int'(a)] = c[1:0];
         end
         "rd": begin
            bus_access(name, 1'b0, a, b, 32'b0, rdata, err, ok);
            if (ok) begin
               check_value(name, c, rdata);
               check_value(name, d, {31'b0, err});
            end
         end
         "set": begin
            @(posedge clk_i);
            drive_source(int'(a), b[13:0]);
         end
         "chk": begin
            @(negedge clk_i);
            check_value(name, b, sink_value(a));
         end
         "rnd": begin  // all direct outputs uniform in -a..a
            @(posedge clk_i);
            for (int k = 0; k < N_DIR; k++) begin
               rng_state = xorshift32(rng_state);
               v = int'(rng_state % (2 * a + 1)) - int'(a);
               drive_source(k, v[13:0]);
            end
         end
         "dac": begin
            wait_mix();
            check_value(name, a, {18'b0, dac_a});
            check_value(name, b, {18'b0, dac_b});
         end
         "mix": begin  // expected sums from the reference copies
            s1 = 0;
            s2 = 0;
            for (int k = 0; k < N_DIR; k++) begin
               if (en_model[k][0]) s1 += dir_val[k];
               if (en_model[k][1]) s2 += dir_val[k];
            end
            wait_mix();
            check_value(name, expect_dac(s1), {18'b0, dac_a});
            check_value(name, expect_dac(s2), {18'b0, dac_b});
         end
         default: begin
            other_cnt++;
            $display("%0s: unknown trace operation %0s", name, op);
         end
      endcase
   endtask

   task automatic load_trace();
      int              fd, r;
      logic [8*24-1:0] name;
      logic [8*8-1:0]  op;
      logic [31:0]     a, b, c, d;
      logic [8*160-1:0] rest;
      fd = $fopen("test/router_trace.txt", "r");
      if (fd == 0) begin
         other_cnt++;
         $display("trace file test/router_trace.txt could not be opened");
         return;
      end
      while ($fscanf(fd, "%s", name) == 1) begin
         if (name == "#") begin
            r = $fgets(rest, fd);  // drop comment text
         end else begin
            r = $fscanf(fd, "%s %h %h %h %h", op, a, b, c, d);
            if (r != 5) begin
               other_cnt++;
               $display("trace line of %0s is malformed", name);
            end else begin
               q_name.push_back(name);
               q_op.push_back(op);
               q_a.push_back(a);
               q_b.push_back(b);
               q_c.push_back(c);
               q_d.push_back(d);
            end
         end
      end
      $fclose(fd);
   endtask

   initial begin
      rstn_i    = 1'b0;
      adc_a     = '0;
      adc_b     = 14'h0a5a;  // scope2 starts on adc2
      asg1      = '0;
      asg2      = '0;
      slot_in   = '0;
      sys_addr  = '0;
      sys_wdata = '0;
      sys_wen   = 1'b0;
      sys_ren   = 1'b0;
      for (int k = 0; k < N_DIR; k++) begin
         dir_val[k]  = 0;
         en_model[k] = 2'b00;  // reset routing has all enables off
      end
      load_trace();
      trace_loaded = 1'b1;
      repeat (10) @(posedge clk_i);
      rstn_i <= 1'b1;
      for (int i = 0; i < q_op.size(); i++)
         run_op(q_name[i], q_op[i], q_a[i], q_b[i], q_c[i], q_d[i]);
      @(negedge clk_i);
      $display("errors: %0d mismatches, %0d other failures", mism_cnt, other_cnt);
      if (mism_cnt == 0 && other_cnt == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

   // watchdog allows 20 cycles per trace step plus reset and margin
   initial begin
      int limit;
      wait (trace_loaded);
      limit = q_op.size() * 20 + 10 + 50;
      repeat (limit) @(posedge clk_i);
      $display("timeout: trace did not finish within %0d cycles", limit);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/dsp_pkg.sv
hw/dsp_reg_bank.sv
hw/signal_crossbar.sv
hw/dac_mixer.sv
hw/dsp_router_top.sv
test/tb_dsp_router.sv
